/* src/lsu_pkg.sv */
package lsu_pkg;

    // --------------------
    // sizes
    // --------------------
    localparam int IQ_DEPTH   = 8;
    localparam int IQ_PTR_W   = 3;
    localparam int CDB_PORTS  = 2;
    localparam int DMEM_WORDS = 64;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  rob_id_t;

    typedef enum logic [1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } mem_size_e;

    // --------------------
    // decoded operation
    // --------------------
    typedef struct packed {
        logic               is_store;
        logic               is_signed;
        mem_size_e          size;
        // offset added to the base operand
        logic signed [11:0] imm;
        rob_id_t            dst;
        logic               wr_reg;
    } mem_op_t;

    // value is only meaningful once ready is set
    typedef struct packed {
        word_t   value;
        rob_id_t tag;
        logic    ready;
    } operand_t;

    // base is operand 1, sdata is operand 0
    typedef struct packed {
        mem_op_t  op;
        operand_t base;
        operand_t sdata;
    } dispatch_t;

    typedef struct packed {
        logic    valid;
        rob_id_t tag;
        word_t   data;
    } cdb_t;

    // --------------------
    // memory side
    // --------------------
    typedef struct packed {
        word_t     vaddr;
        word_t     wdata;
        logic [3:0] strb;
        logic      is_store;
        logic      is_signed;
        mem_size_e size;
        rob_id_t   dst;
        logic      wr_reg;
    } mem_req_t;

    typedef struct packed {
        rob_id_t dst;
        logic    wr_reg;
        logic    is_store;
        word_t   data;
        word_t   store_data;
    } lsu_result_t;

endpackage

/* src/lsu_iq_entry.sv */
`timescale 1ns/1ps

module lsu_iq_entry (
    input  logic                                   clk,
    input  logic                                   rst_n_i,
    input  logic                                   flush_i,
    input  logic                                   init_i,
    input  lsu_pkg::dispatch_t                     op_i,
    input  lsu_pkg::cdb_t [lsu_pkg::CDB_PORTS-1:0] cdb_i,
    input  logic                                   issue_i,
    output logic                                   valid_o,
    output logic                                   ready_o,
    output lsu_pkg::dispatch_t                     op_o
);

    logic               valid_q;
    lsu_pkg::dispatch_t op_q;
    lsu_pkg::dispatch_t op_src;
    lsu_pkg::dispatch_t op_nxt;

    // pick up a pending operand from any matching writeback port
    function automatic lsu_pkg::operand_t snoop(
        input lsu_pkg::operand_t                     opnd,
        input lsu_pkg::cdb_t [lsu_pkg::CDB_PORTS-1:0] cdb
    );
        lsu_pkg::operand_t res;
        res = opnd;
        for (int p = 0; p < lsu_pkg::CDB_PORTS; p++) begin
            if (!opnd.ready && cdb[p].valid && cdb[p].tag == opnd.tag) begin
                res.value = cdb[p].data;
                res.ready = 1'b1;
            end
        end
        return res;
    endfunction

    // --------------------
    // operand capture
    // --------------------
    // new op snoops the bus too, so a same-cycle broadcast is not missed
    always_comb begin
        op_src       = init_i ? op_i : op_q;
        op_nxt       = op_src;
        op_nxt.base  = snoop(op_src.base, cdb_i);
        op_nxt.sdata = snoop(op_src.sdata, cdb_i);
    end

    always_ff @(posedge clk) begin
        if (init_i || valid_q) begin
            op_q <= op_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            valid_q <= 1'b0;
        end else if (init_i) begin
            valid_q <= 1'b1;
        end else if (issue_i) begin
            valid_q <= 1'b0;
        end
    end

    assign valid_o = valid_q;
    assign ready_o = valid_q && op_q.base.ready && op_q.sdata.ready;
    assign op_o    = op_q;

    // queue must only write into free slots
    a_init_free: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        init_i |-> !valid_q
    );

endmodule

/* src/lsu_iq.sv */
`timescale 1ns/1ps

module lsu_iq (
    input  logic                                   clk,
    input  logic                                   rst_n_i,
    input  logic                                   flush_i,
    input  lsu_pkg::dispatch_t [1:0]               disp_i,
    input  logic [1:0]                             disp_valid_i,
    output logic                                   disp_ready_o,
    input  lsu_pkg::cdb_t [lsu_pkg::CDB_PORTS-1:0] cdb_i,
    output logic                                   req_valid_o,
    input  logic                                   req_ready_i,
    output lsu_pkg::mem_req_t                      req_o
);

    // ring state
    logic [lsu_pkg::IQ_PTR_W-1:0] head_q;
    logic [lsu_pkg::IQ_PTR_W-1:0] tail_q;
    logic [lsu_pkg::IQ_PTR_W-1:0] tail_p1;
    logic [lsu_pkg::IQ_PTR_W:0]   free_q;
    logic [lsu_pkg::IQ_PTR_W:0]   free_nxt;

    logic [1:0] accept;
    logic [1:0] n_accept;

    logic [lsu_pkg::IQ_DEPTH-1:0]               slot_init;
    logic [lsu_pkg::IQ_DEPTH-1:0]               slot_issue;
    logic [lsu_pkg::IQ_DEPTH-1:0]               slot_valid;
    logic [lsu_pkg::IQ_DEPTH-1:0]               slot_ready;
    lsu_pkg::dispatch_t [lsu_pkg::IQ_DEPTH-1:0] slot_in;
    lsu_pkg::dispatch_t [lsu_pkg::IQ_DEPTH-1:0] slot_op;

    lsu_pkg::dispatch_t first_op;
    lsu_pkg::dispatch_t head_op;
    logic               head_ready;
    logic               issue_ok;
    logic               do_issue;

    lsu_pkg::word_t    vaddr;
    logic [1:0]        byte_off;
    lsu_pkg::mem_req_t req_nxt;

    // --------------------
    // dispatch
    // --------------------
    assign accept   = disp_valid_i & {2{disp_ready_o}};
    assign n_accept = {1'b0, accept[0]} + {1'b0, accept[1]};
    assign tail_p1  = tail_q + 1'b1;

    // a lone lane always lands at the tail
    assign first_op = accept[0] ? disp_i[0] : disp_i[1];

    always_comb begin
        slot_init = '0;
        for (int i = 0; i < lsu_pkg::IQ_DEPTH; i++) begin
            slot_in[i] = first_op;
        end
        if (|accept) begin
            slot_init[tail_q] = 1'b1;
        end
        if (&accept) begin
            slot_init[tail_p1] = 1'b1;
            slot_in[tail_p1]   = disp_i[1];
        end
    end

    // --------------------
    // in-order select
    // --------------------
    assign head_op    = slot_op[head_q];
    assign head_ready = slot_ready[head_q];
    assign issue_ok   = !req_valid_o || req_ready_i;
    assign do_issue   = issue_ok && head_ready;

    always_comb begin
        slot_issue         = '0;
        slot_issue[head_q] = do_issue;
    end

    assign free_nxt = free_q - (lsu_pkg::IQ_PTR_W + 1)'(n_accept)
                             + (lsu_pkg::IQ_PTR_W + 1)'(do_issue);

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            head_q       <= '0;
            tail_q       <= '0;
            free_q       <= (lsu_pkg::IQ_PTR_W + 1)'(lsu_pkg::IQ_DEPTH);
            disp_ready_o <= 1'b1;
        end else begin
            head_q       <= head_q + lsu_pkg::IQ_PTR_W'(do_issue);
            tail_q       <= tail_q + lsu_pkg::IQ_PTR_W'(n_accept);
            free_q       <= free_nxt;
            // room for a full dual dispatch
            disp_ready_o <= free_nxt >= 2;
        end
    end

    for (genvar i = 0; i < lsu_pkg::IQ_DEPTH; i++) begin : g_slot
        lsu_iq_entry u_entry (
            .clk     (clk),
            .rst_n_i (rst_n_i),
            .flush_i (flush_i),
            .init_i  (slot_init[i]),
            .op_i    (slot_in[i]),
            .cdb_i   (cdb_i),
            .issue_i (slot_issue[i]),
            .valid_o (slot_valid[i]),
            .ready_o (slot_ready[i]),
            .op_o    (slot_op[i])
        );
    end

    // --------------------
    // address generation
    // --------------------
    assign vaddr    = head_op.base.value
                    + {{20{head_op.op.imm[11]}}, head_op.op.imm};
    assign byte_off = vaddr[1:0];

    always_comb begin
        req_nxt.vaddr     = vaddr;
        // move store data into its byte lane
        req_nxt.wdata     = head_op.sdata.value << {byte_off, 3'b000};
        req_nxt.is_store  = head_op.op.is_store;
        req_nxt.is_signed = head_op.op.is_signed;
        req_nxt.size      = head_op.op.size;
        req_nxt.dst       = head_op.op.dst;
        req_nxt.wr_reg    = head_op.op.wr_reg;
        case (head_op.op.size)
            lsu_pkg::MEM_BYTE: req_nxt.strb = 4'b0001 << byte_off;
            lsu_pkg::MEM_HALF: req_nxt.strb = 4'b0011 << byte_off;
            default:           req_nxt.strb = 4'b1111;
        endcase
        if (!head_op.op.is_store) begin
            req_nxt.strb = '0;
        end
    end

    // request register, one deep
    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            req_valid_o <= 1'b0;
        end else if (issue_ok) begin
            req_valid_o <= head_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (do_issue) begin
            req_o <= req_nxt;
        end
    end

    // free count agrees with the slots actually holding ops
    a_free_cnt: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        free_q <= lsu_pkg::IQ_DEPTH
            && free_q + $countones(slot_valid) == lsu_pkg::IQ_DEPTH
    );

    a_req_hold: assert property (
        @(posedge clk) disable iff (!rst_n_i || flush_i)
        req_valid_o && !req_ready_i |=> req_valid_o && $stable(req_o)
    );

endmodule

/* src/lsu_dmem.sv */
`timescale 1ns/1ps

module lsu_dmem (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 flush_i,
    input  logic                 req_valid_i,
    output logic                 req_ready_o,
    input  lsu_pkg::mem_req_t    req_i,
    output logic                 res_valid_o,
    input  logic                 res_ready_i,
    output lsu_pkg::lsu_result_t res_o
);

    lsu_pkg::word_t mem_q [lsu_pkg::DMEM_WORDS];

    logic                req_fire;
    logic [5:0]          word_idx;
    lsu_pkg::word_t      rd_word;
    lsu_pkg::word_t      rd_shift;
    lsu_pkg::word_t      load_data;
    lsu_pkg::word_t      strb_mask;
    lsu_pkg::lsu_result_t res_nxt;

    // stall whenever the result is stuck
    assign req_ready_o = !res_valid_o || res_ready_i;
    assign req_fire    = req_valid_i && req_ready_o;
    assign word_idx    = req_i.vaddr[7:2];

    // --------------------
    // storage
    // --------------------
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int w = 0; w < lsu_pkg::DMEM_WORDS; w++) begin
                mem_q[w] <= '0;
            end
        end else if (req_fire && req_i.is_store) begin
            for (int b = 0; b < 4; b++) begin
                if (req_i.strb[b]) begin
                    mem_q[word_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
                end
            end
        end
    end

    // --------------------
    // load extract
    // --------------------
    assign rd_word  = mem_q[word_idx];
    assign rd_shift = rd_word >> {req_i.vaddr[1:0], 3'b000};

    always_comb begin
        case (req_i.size)
            lsu_pkg::MEM_BYTE: begin
                load_data = req_i.is_signed ? {{24{rd_shift[7]}}, rd_shift[7:0]}
                                            : {24'd0, rd_shift[7:0]};
            end
            lsu_pkg::MEM_HALF: begin
                load_data = req_i.is_signed ? {{16{rd_shift[15]}}, rd_shift[15:0]}
                                            : {16'd0, rd_shift[15:0]};
            end
            default: load_data = rd_shift;
        endcase
    end

    // only the written bytes are reported back
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            strb_mask[8*b +: 8] = {8{req_i.strb[b]}};
        end
    end

    always_comb begin
        res_nxt.dst        = req_i.dst;
        res_nxt.wr_reg     = req_i.wr_reg;
        res_nxt.is_store   = req_i.is_store;
        res_nxt.data       = req_i.is_store ? '0 : load_data;
        res_nxt.store_data = req_i.wdata & strb_mask;
    end

    // result register
    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            res_valid_o <= 1'b0;
        end else if (req_ready_o) begin
            res_valid_o <= req_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            res_o <= res_nxt;
        end
    end

    a_res_hold: assert property (
        @(posedge clk) disable iff (!rst_n_i || flush_i)
        res_valid_o && !res_ready_i |=> res_valid_o && $stable(res_o)
    );

endmodule

/* src/lsu_top.sv */
`timescale 1ns/1ps

module lsu_top (
    input  logic                                   clk,
    input  logic                                   rst_n_i,
    input  logic                                   flush_i,
    input  lsu_pkg::dispatch_t [1:0]               disp_i,
    input  logic [1:0]                             disp_valid_i,
    output logic                                   disp_ready_o,
    input  lsu_pkg::cdb_t [lsu_pkg::CDB_PORTS-1:0] cdb_i,
    output logic                                   res_valid_o,
    input  logic                                   res_ready_i,
    output lsu_pkg::lsu_result_t                   res_o
);

    // queue to memory
    logic              req_valid;
    logic              req_ready;
    lsu_pkg::mem_req_t req;

    lsu_iq iq0 (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .disp_i       (disp_i),
        .disp_valid_i (disp_valid_i),
        .disp_ready_o (disp_ready_o),
        .cdb_i        (cdb_i),
        .req_valid_o  (req_valid),
        .req_ready_i  (req_ready),
        .req_o        (req)
    );

    lsu_dmem dmem0 (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .req_valid_i (req_valid),
        .req_ready_o (req_ready),
        .req_i       (req),
        .res_valid_o (res_valid_o),
        .res_ready_i (res_ready_i),
        .res_o       (res_o)
    );

endmodule

/* testbench/tb_lsu_top.sv */
`timescale 1ns/1ps

module tb_lsu_top;

    localparam int RESET_CYCLES = 16;
    // 2 + 19 + 4 + 10 + 10 operations over the five tests
    localparam int N_OPS        = 45;
    localparam int CYCLE_LIMIT  = 40 * N_OPS + RESET_CYCLES;

    logic                                   clk;
    logic                                   rst_n_i;
    logic                                   flush_i;
    lsu_pkg::dispatch_t [1:0]               disp_i;
    logic [1:0]                             disp_valid_i;
    logic                                   disp_ready_o;
    lsu_pkg::cdb_t [lsu_pkg::CDB_PORTS-1:0] cdb_i;
    logic                                   res_valid_o;
    logic                                   res_ready_i;
    lsu_pkg::lsu_result_t                   res_o;

    logic [31:0]          lfsr_q;
    logic [7:0]           mem_model [256];
    lsu_pkg::lsu_result_t exp_q [$];
    lsu_pkg::rob_id_t     dst_cnt;
    lsu_pkg::lsu_result_t held_res;
    lsu_pkg::lsu_result_t exp_r;
    logic                 was_stalled = 1'b0;
    int                   res_cnt = 0;
    int                   cycle_cnt = 0;

    lsu_top dut0 (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .disp_i       (disp_i),
        .disp_valid_i (disp_valid_i),
        .disp_ready_o (disp_ready_o),
        .cdb_i        (cdb_i),
        .res_valid_o  (res_valid_o),
        .res_ready_i  (res_ready_i),
        .res_o        (res_o)
    );

    always #2 clk = ~clk;

    // --------------------
    // helpers
    // --------------------
    // x^32 + x^22 + x^2 + x + 1 in right-shifting form
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v      = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic compare_result(input lsu_pkg::lsu_result_t got, input lsu_pkg::lsu_result_t exp);
        check("res_o.dst", 32'(got.dst), 32'(exp.dst));
        check("res_o.wr_reg", 32'(got.wr_reg), 32'(exp.wr_reg));
        check("res_o.is_store", 32'(got.is_store), 32'(exp.is_store));
        check("res_o.data", got.data, exp.data);
        check("res_o.store_data", got.store_data, exp.store_data);
    endtask

    // byte-array memory, updated in dispatch order since ops execute in order
    task automatic model_op(input logic st, input logic sg, input lsu_pkg::mem_size_e sz,
                            input logic [7:0] addr, input lsu_pkg::word_t wd,
                            input lsu_pkg::rob_id_t dst);
        lsu_pkg::lsu_result_t r;
        logic [31:0]          v;
        int                   n;
        n = (sz == lsu_pkg::MEM_BYTE) ? 1 : (sz == lsu_pkg::MEM_HALF) ? 2 : 4;
        r = '0;
        v = '0;
        r.dst      = dst;
        r.wr_reg   = !st;
        r.is_store = st;
        for (int i = 0; i < n; i++) begin
            if (st) begin
                mem_model[addr + 8'(i)]                = wd[8*i +: 8];
                r.store_data[8*(addr[1:0] + i) +: 8] = wd[8*i +: 8];
            end else begin
                v[8*i +: 8] = mem_model[addr + 8'(i)];
            end
        end
        if (!st && sg && n == 1) v = {{24{v[7]}}, v[7:0]};
        if (!st && sg && n == 2) v = {{16{v[15]}}, v[15:0]};
        r.data = v;
        exp_q.push_back(r);
    endtask

    // base = addr - imm; a pending base carries a wrong value until the CDB fills it
    task automatic make_op(input logic st, input logic sg, input lsu_pkg::mem_size_e sz,
                           input logic [7:0] addr, input lsu_pkg::word_t wd, input logic pend,
                           input lsu_pkg::rob_id_t tag, input logic track,
                           output lsu_pkg::dispatch_t d, output lsu_pkg::word_t base);
        logic [11:0] imm;
        imm  = 12'(rand_bits(12));
        base = {24'(rand_bits(24)), addr} - {{20{imm[11]}}, imm};
        d    = '0;
        d.op.is_store  = st;
        d.op.is_signed = sg;
        d.op.size      = sz;
        d.op.imm       = imm;
        d.op.dst       = dst_cnt;
        d.op.wr_reg    = !st;
        d.base.value   = pend ? ~base : base;
        d.base.tag     = tag;
        d.base.ready   = !pend;
        d.sdata.value  = wd;
        d.sdata.ready  = 1'b1;
        if (track) model_op(st, sg, sz, addr, wd, dst_cnt);
        dst_cnt = dst_cnt + 1'b1;
    endtask

    task automatic send(input lsu_pkg::dispatch_t d0, input lsu_pkg::dispatch_t d1,
                        input logic [1:0] v);
        @(posedge clk);
        disp_i[0]    <= d0;
        disp_i[1]    <= d1;
        disp_valid_i <= v;
        do @(negedge clk); while (!disp_ready_o);
        @(posedge clk);
        disp_valid_i <= 2'b00;
    endtask

    task automatic broadcast(input logic [1:0] en, input lsu_pkg::rob_id_t t0,
                             input lsu_pkg::word_t d0, input lsu_pkg::rob_id_t t1,
                             input lsu_pkg::word_t d1);
        @(posedge clk);
        cdb_i[0] <= {en[0], t0, d0};
        cdb_i[1] <= {en[1], t1, d1};
        @(posedge clk);
        cdb_i    <= '0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) @(posedge clk);
    endtask

    // --------------------
    // directed tests
    // --------------------
    task automatic test_store_load();
        lsu_pkg::dispatch_t d0, d1;
        lsu_pkg::word_t     b;
        make_op(1'b1, 1'b0, lsu_pkg::MEM_WORD, 8'h40, 32'hcafe_f00d, 1'b0, '0, 1'b1, d0, b);
        make_op(1'b0, 1'b0, lsu_pkg::MEM_WORD, 8'h40, '0, 1'b0, '0, 1'b1, d1, b);
        send(d0, d1, 2'b11);
        drain();
    endtask

    task automatic test_byte_half();
        lsu_pkg::dispatch_t d;
        lsu_pkg::word_t     b;
        make_op(1'b1, 1'b0, lsu_pkg::MEM_WORD, 8'h84, rand_bits(32), 1'b0, '0, 1'b1, d, b);
        send(d, d, 2'b01);
        // odd offsets get a byte with the sign bit set
        for (int o = 0; o < 4; o++) begin
            make_op(1'b1, 1'b0, lsu_pkg::MEM_BYTE, 8'h84 + 8'(o),
                    {24'(rand_bits(24)), o[0], 7'(rand_bits(7))}, 1'b0, '0, 1'b1, d, b);
            send(d, d, o[0] ? 2'b10 : 2'b01);
        end
        // only the upper half is negative
        for (int o = 0; o < 4; o += 2) begin
            make_op(1'b1, 1'b0, lsu_pkg::MEM_HALF, 8'h88 + 8'(o),
                    {16'(rand_bits(16)), o[1], 15'(rand_bits(15))}, 1'b0, '0, 1'b1, d, b);
            send(d, d, 2'b10);
        end
        for (int o = 0; o < 8; o++) begin
            make_op(1'b0, o[0], lsu_pkg::MEM_BYTE, 8'h84 + 8'(o >> 1), '0, 1'b0, '0, 1'b1, d, b);
            send(d, d, o[1] ? 2'b10 : 2'b01);
        end
        for (int o = 0; o < 4; o++) begin
            make_op(1'b0, o[0], lsu_pkg::MEM_HALF, 8'h88 + 8'(o & 2), '0, 1'b0, '0, 1'b1, d, b);
            send(d, d, 2'b01);
        end
        drain();
    endtask

    task automatic test_pending();
        lsu_pkg::dispatch_t d0, d1;
        lsu_pkg::word_t     b0, b1;
        int                 n;
        // older store waits on tag 7, younger load behind it is ready
        make_op(1'b1, 1'b0, lsu_pkg::MEM_WORD, 8'h90, rand_bits(32), 1'b1, 5'd7, 1'b1, d0, b0);
        make_op(1'b0, 1'b0, lsu_pkg::MEM_WORD, 8'h90, '0, 1'b0, '0, 1'b1, d1, b1);
        send(d0, d1, 2'b11);
        n = res_cnt;
        repeat (10) @(posedge clk);
        check("results before tag 7", 32'(res_cnt), 32'(n));
        broadcast(2'b01, 5'd7, b0, '0, '0);
        drain();
        make_op(1'b0, 1'b1, lsu_pkg::MEM_HALF, 8'h92, '0, 1'b1, 5'd9, 1'b1, d0, b0);
        make_op(1'b0, 1'b0, lsu_pkg::MEM_BYTE, 8'h93, '0, 1'b1, 5'd10, 1'b1, d1, b1);
        send(d0, d1, 2'b11);
        n = res_cnt;
        repeat (10) @(posedge clk);
        check("results before tags 9 and 10", 32'(res_cnt), 32'(n));
        broadcast(2'b11, 5'd10, b1, 5'd9, b0);
        drain();
    endtask

    task automatic test_backpressure();
        lsu_pkg::dispatch_t d [2];
        lsu_pkg::mem_size_e sz;
        lsu_pkg::word_t     b;
        logic [7:0]         addr;
        logic [1:0]         sel;
        @(posedge clk);
        res_ready_i <= 1'b0;
        for (int p = 0; p < 5; p++) begin
            for (int l = 0; l < 2; l++) begin
                sel  = 2'(rand_bits(2));
                sz   = (sel == 2'd0) ? lsu_pkg::MEM_BYTE
                     : (sel == 2'd1) ? lsu_pkg::MEM_HALF : lsu_pkg::MEM_WORD;
                addr = 8'(rand_bits(8));
                if (sz == lsu_pkg::MEM_HALF) addr[0] = 1'b0;
                if (sz == lsu_pkg::MEM_WORD) addr[1:0] = 2'b00;
                make_op(rand_bits(1) != 0, rand_bits(1) != 0, sz, addr, rand_bits(32), 1'b0,
                        '0, 1'b1, d[l], b);
            end
            send(d[0], d[1], 2'b11);
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        check("disp_ready_o with queue full", 32'(disp_ready_o), 32'd0);
        while (exp_q.size() != 0) begin
            @(posedge clk);
            res_ready_i <= rand_bits(2) != 0;
        end
        @(posedge clk);
        res_ready_i <= 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check("disp_ready_o after drain", 32'(disp_ready_o), 32'd1);
    endtask

    task automatic test_flush();
        lsu_pkg::dispatch_t d0, d1;
        lsu_pkg::word_t     b0, b1;
        int                 n;
        make_op(1'b1, 1'b0, lsu_pkg::MEM_WORD, 8'ha0, rand_bits(32), 1'b0, '0, 1'b1, d0, b0);
        send(d0, d0, 2'b01);
        drain();
        // none of these are expected to produce a result
        make_op(1'b0, 1'b0, lsu_pkg::MEM_WORD, 8'ha0, '0, 1'b1, 5'd20, 1'b0, d0, b0);
        make_op(1'b0, 1'b1, lsu_pkg::MEM_BYTE, 8'ha1, '0, 1'b1, 5'd21, 1'b0, d1, b1);
        send(d0, d1, 2'b11);
        make_op(1'b1, 1'b0, lsu_pkg::MEM_WORD, 8'ha0, 32'hffff_0000, 1'b0, '0, 1'b0, d0, b0);
        make_op(1'b0, 1'b0, lsu_pkg::MEM_WORD, 8'ha0, '0, 1'b0, '0, 1'b0, d1, b1);
        send(d0, d1, 2'b11);
        // fill the rest of the queue behind the blocked head
        for (int p = 0; p < 2; p++) begin
            make_op(1'b1, 1'b0, lsu_pkg::MEM_WORD, 8'ha0, rand_bits(32), 1'b0, '0, 1'b0,
                    d0, b0);
            make_op(1'b0, 1'b0, lsu_pkg::MEM_WORD, 8'ha0, '0, 1'b0, '0, 1'b0, d1, b1);
            send(d0, d1, 2'b11);
        end
        n = res_cnt;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check("disp_ready_o before flush", 32'(disp_ready_o), 32'd0);
        @(posedge clk);
        flush_i <= 1'b1;
        @(posedge clk);
        flush_i <= 1'b0;
        @(negedge clk);
        check("disp_ready_o after flush", 32'(disp_ready_o), 32'd1);
        broadcast(2'b11, 5'd20, '0, 5'd21, '0);
        repeat (8) @(posedge clk);
        check("results after flush", 32'(res_cnt), 32'(n));
        make_op(1'b0, 1'b0, lsu_pkg::MEM_WORD, 8'ha0, '0, 1'b0, '0, 1'b1, d0, b0);
        send(d0, d0, 2'b01);
        drain();
    endtask

    // --------------------
    // result monitor
    // --------------------
    always @(negedge clk) begin
        if (!rst_n_i || flush_i) begin
            was_stalled = 1'b0;
        end else begin
            if (was_stalled) begin
                if (!res_valid_o) fail_run("result dropped while res_ready_i was low");
                compare_result(res_o, held_res);
            end
            if (res_valid_o && res_ready_i) begin
                if (exp_q.size() == 0) fail_run("result arrived with no operation expected");
                exp_r = exp_q.pop_front();
                compare_result(res_o, exp_r);
                res_cnt++;
            end
            was_stalled = res_valid_o && !res_ready_i;
            held_res    = res_o;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            fail_run($sformatf("timeout after %0d cycles, DUT stopped responding", cycle_cnt));
        end
    end

    initial begin
        clk          = 1'b0;
        rst_n_i      = 1'b0;
        flush_i      = 1'b0;
        disp_i       = '0;
        disp_valid_i = 2'b00;
        cdb_i        = '0;
        res_ready_i  = 1'b1;
        lfsr_q       = 32'h9a88_77b6;
        dst_cnt      = '0;
        for (int i = 0; i < 256; i++) mem_model[i] = 8'h00;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n_i <= 1'b1;
        test_store_load();
        test_byte_half();
        test_pending();
        test_backpressure();
        test_flush();
        repeat (4) @(posedge clk);
        if (exp_q.size() == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            fail_run("results still missing at the end of the run");
        end
    end

endmodule

/* project.f */
src/lsu_pkg.sv
src/lsu_iq_entry.sv
src/lsu_iq.sv
src/lsu_dmem.sv
src/lsu_top.sv
testbench/tb_lsu_top.sv

/* Makefile */
TOP = tb_lsu_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "All tests passed!" sim.log

lint:
	verilator --lint-only -Wall -f project.f --top-module lsu_top

clean:
	rm -rf obj_dir sim.log
